// File: sprite_bitmap_rom.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_bitmap_rom
  import sprite_pkg::*;
(
  input  logic [rom_addr_bits-1:0] addr, // {shape, row}
  output logic [rom_data_bits-1:0] data  // bit i is column i of the row
);

  logic [rom_data_bits-1:0] rom [1 << rom_addr_bits];

  // 4 shapes x 16 rows
  initial begin
    $readmemh("sprite_bitmaps.hex", rom);
  end

  // combinational read, data valid in the same cycle
  assign data = rom[addr];

endmodule

`default_nettype wire

// File: sprite_bitmaps.hex
// one 16-bit row per line, bit i is column i; 4 shapes of 16 rows, shape 0 first
FFFF
8001
8001
8001
8001
8001
8001
8001
8001
8001
8001
8001
8001
8001
8001
FFFF
0001
0002
0004
0008
0010
0020
0040
0080
0100
0200
0400
0800
1000
2000
4000
8000
07E0
1FF8
3FFC
7FFE
7FFE
FFFF
FFFF
FFFF
FFFF
FFFF
FFFF
7FFE
7FFE
3FFC
1FF8
07E0
0003
000F
003F
00FF
03FF
0FFF
3FFF
FFFF
FFFF
3FFF
0FFF
03FF
00FF
003F
000F
0003

// File: sprite_pkg.sv
`default_nettype none

package sprite_pkg;

  // raster geometry, clocks per line and lines per frame
  localparam int h_total      = 320;
  localparam int h_visible    = 256;
  localparam int h_sync_start = 280; // hsync while hpos in [start, end)
  localparam int h_sync_end   = 304;
  localparam int v_total      = 262;
  localparam int v_visible    = 240;
  localparam int v_render     = 256; // renderer draws below this line
  localparam int v_sync_start = 244;
  localparam int v_sync_end   = 247;
  localparam int v_load_line  = 260; // sprite table copied here
  localparam int pos_bits     = 9;

  // sprite sizes
  localparam int sprite_count      = 16;
  localparam int sprite_index_bits = 4;
  localparam int slots_per_line    = 4;
  localparam int slot_bits         = 2;
  localparam int sprite_size       = 16; // width and height in pixels
  localparam int coord_bits        = 8;  // x and y positions wrap at 256
  localparam int shape_bits        = 2;
  localparam int color_bits        = 4;
  localparam int attr_bits         = shape_bits + color_bits;

  // sprite table, two words per sprite
  //   word 2n   y in [15:8], x in [7:0]
  //   word 2n+1 attribute in [7:0], shape in [5:4], color in [3:0]
  localparam int table_addr_bits = 5;
  localparam int table_data_bits = 16;
  localparam int table_words     = 1 << table_addr_bits;

  // bitmap rom, shape in upper address bits, row in lower
  localparam int rom_addr_bits = 6;
  localparam int rom_data_bits = 16;

  // phase windows in hpos
  localparam int load_end   = table_words + 2; // registered address plus sync read
  localparam int select_end = sprite_count * 2; // two clocks per sprite
  localparam int raster_end = select_end + slots_per_line * (sprite_size + 2);

  typedef enum logic [2:0] {
    phase_load,   // copying the table on the load line
    phase_select, // scanning sprites for this line
    phase_raster, // drawing slots into the back bank
    phase_idle,   // rest of a render line
    phase_off     // no rendering
  } render_phase_e;

endpackage

`default_nettype wire

// File: sprite_scanline_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_scanline_renderer
  import sprite_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic [pos_bits-1:0]        hpos,
  input  logic [pos_bits-1:0]        vpos,
  output logic [table_addr_bits-1:0] table_addr,
  input  logic [table_data_bits-1:0] table_data,
  output logic [rom_addr_bits-1:0]   rom_addr,
  input  logic [rom_data_bits-1:0]   rom_data,
  output logic [color_bits-1:0]      rgb
);

  // local copy of the table, refreshed on the load line
  logic [coord_bits-1:0] sprite_x    [sprite_count];
  logic [coord_bits-1:0] sprite_y    [sprite_count];
  logic [attr_bits-1:0]  sprite_attr [sprite_count];

  // line slots filled by selection
  logic [coord_bits-1:0] line_x      [slots_per_line];
  logic [3:0]            line_yofs   [slots_per_line]; // row inside the sprite
  logic [attr_bits-1:0]  line_attr   [slots_per_line];
  logic                  line_active [slots_per_line];

  // double scanline buffer, bank = line parity
  logic [color_bits-1:0] scanline [2 << coord_bits];

  render_phase_e              phase;
  logic                       loaded;      // first copy done
  logic [coord_bits-1:0]      z;           // line minus sprite y
  logic [slot_bits:0]         slot_count;  // slots taken on this line
  logic [slot_bits:0]         slot_k;      // slot being drawn
  logic                       romload;     // second clock of a fetch
  logic [rom_data_bits-1:0]   out_bitmap;  // pixels left to draw
  logic [color_bits-1:0]      out_color;
  logic [coord_bits-1:0]      write_col;
  logic [pos_bits-1:0]        cap_pos;
  logic [sprite_index_bits-1:0] sel_idx;
  logic [slot_bits-1:0]       slot;
  logic [coord_bits:0]        rd_idx;
  logic                       sel_even;
  logic                       take_slot;
  logic                       fetch_busy;
  logic                       fetch_cap;
  logic                       shifting;
  logic                       buf_we;
  logic                       load_cap;
  logic                       visible;

  // phase from raster position only
  always_comb begin
    if (vpos == v_load_line) begin
      phase = (hpos < load_end) ? phase_load : phase_off;
    end else if (vpos >= v_render) begin
      phase = phase_off;
    end else if (hpos < select_end) begin
      phase = phase_select;
    end else if (hpos < raster_end) begin
      phase = phase_raster;
    end else begin
      phase = phase_idle;
    end
  end

  assign cap_pos = hpos - pos_bits'(2); // word arriving now was addressed 2 clocks ago
  assign sel_idx = hpos[sprite_index_bits:1];
  assign slot    = slot_k[slot_bits-1:0];
  assign rd_idx  = {vpos[0], hpos[coord_bits-1:0]};
  assign visible = (hpos < h_visible) && (vpos < v_visible);

  assign load_cap   = (phase == phase_load) && (hpos >= 2);
  assign sel_even   = (phase == phase_select) && !hpos[0];
  assign take_slot  = (phase == phase_select) && hpos[0] && loaded &&
                      (z < sprite_size) && (slot_count < slots_per_line);
  assign fetch_busy = (phase == phase_raster) && (out_bitmap == '0) && !slot_k[slot_bits];
  assign fetch_cap  = fetch_busy && romload;
  assign shifting   = (phase == phase_raster) && (out_bitmap != '0);
  assign buf_we     = shifting && out_bitmap[0]; // opaque pixel

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      table_addr <= '0;
      rom_addr   <= '0;
      loaded     <= 1'b0;
      slot_count <= '0;
      slot_k     <= '0;
      romload    <= 1'b0;
      out_bitmap <= '0;
      for (int s = 0; s < slots_per_line; s++) begin
        line_active[s] <= 1'b0;
      end
    end else begin
      if (phase == phase_load) begin
        table_addr <= hpos[table_addr_bits-1:0]; // word hpos
        if (hpos == load_end - 1) loaded <= 1'b1;
      end
      if (phase == phase_select) begin
        slot_k  <= '0;   // raster starts at slot 0
        romload <= 1'b0;
        if (hpos == 0) begin
          slot_count <= '0;
          for (int s = 0; s < slots_per_line; s++) begin
            line_active[s] <= 1'b0; // drop last line's slots
          end
        end
      end
      if (take_slot) begin
        line_active[slot_count[slot_bits-1:0]] <= 1'b1;
        slot_count <= slot_count + 1'b1;
      end
      if (fetch_busy) begin
        romload <= !romload;
        if (!romload) begin
          rom_addr <= {line_attr[slot][attr_bits-1:color_bits], line_yofs[slot]};
        end else begin
          out_bitmap <= line_active[slot] ? rom_data : '0; // empty slot draws nothing
          slot_k     <= slot_k + 1'b1;
        end
      end else if (shifting) begin
        out_bitmap <= out_bitmap >> 1; // next column into bit 0
      end
    end
  end

  // sprite copy, slot payload and draw position
  always_ff @(posedge clk) begin
    if (load_cap) begin
      if (!cap_pos[0]) begin
        sprite_y[cap_pos[sprite_index_bits:1]] <= table_data[15:8];
        sprite_x[cap_pos[sprite_index_bits:1]] <= table_data[7:0];
      end else begin
        sprite_attr[cap_pos[sprite_index_bits:1]] <= table_data[attr_bits-1:0];
      end
    end
    if (sel_even) z <= vpos[coord_bits-1:0] - sprite_y[sel_idx]; // mod 256
    if (take_slot) begin
      line_x[slot_count[slot_bits-1:0]]    <= sprite_x[sel_idx];
      line_yofs[slot_count[slot_bits-1:0]] <= z[3:0];
      line_attr[slot_count[slot_bits-1:0]] <= sprite_attr[sel_idx];
    end
    if (fetch_cap) begin
      write_col <= line_x[slot];
      out_color <= line_attr[slot][color_bits-1:0];
    end else if (shifting) begin
      write_col <= write_col + 1'b1; // wraps inside the bank
    end
  end

  // back bank gets drawn, front bank read and cleared
  always_ff @(posedge clk) begin
    if (buf_we) scanline[{~vpos[0], write_col}] <= out_color; // later slot wins
    scanline[rd_idx] <= '0;
  end

  // registered pixel, one clock behind hpos
  always_ff @(posedge clk) begin
    if (rst) begin
      rgb <= '0;
    end else if (visible && loaded) begin
      rgb <= scanline[rd_idx];
    end else begin
      rgb <= '0; // blanking, or buffer not yet clean
    end
  end

endmodule

`default_nettype wire

// File: sprite_table.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_table
  import sprite_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  // host write port
  input  logic                       wr_en,
  input  logic [table_addr_bits-1:0] wr_addr,
  input  logic [table_data_bits-1:0] wr_data,
  // renderer read port
  input  logic [table_addr_bits-1:0] rd_addr,
  output logic [table_data_bits-1:0] rd_data
);

  // two words per sprite, layout in sprite_pkg
  logic [table_data_bits-1:0] mem [table_words];

  // host writes always land, no arbitration needed
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // one clock read latency
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_addr]; // old data on a same-address write
    end
  end

endmodule

`default_nettype wire

// File: sprite_video_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_video_asserts
  import sprite_pkg::*;
(
  input logic                  clk,
  input logic                  rst,
  input logic [pos_bits-1:0]   hpos,
  input logic [pos_bits-1:0]   vpos,
  input logic                  hsync,
  input logic                  vsync,
  input logic [color_bits-1:0] rgb
);

  // raster counters stay inside the frame
  hpos_range: assert property (@(posedge clk) disable iff (rst) hpos < h_total)
    else $error("hpos outside 0..%0d", h_total - 1);
  vpos_range: assert property (@(posedge clk) disable iff (rst) vpos < v_total)
    else $error("vpos outside 0..%0d", v_total - 1);

  // syncs only inside their windows
  hsync_window: assert property (@(posedge clk) disable iff (rst)
      hsync |-> (hpos >= h_sync_start) && (hpos < h_sync_end))
    else $error("hsync high at hpos %0d", hpos);
  vsync_window: assert property (@(posedge clk) disable iff (rst)
      vsync |-> (vpos >= v_sync_start) && (vpos < v_sync_end))
    else $error("vsync high on line %0d", vpos);

  // rgb trails its raster position by one clock
  rgb_blank: assert property (@(posedge clk) disable iff (rst)
      !((hpos < h_visible) && (vpos < v_visible)) |=> (rgb == '0))
    else $error("rgb not black outside the visible window");

endmodule

// timing outputs and renderer pixel side by side at the core boundary
bind sprite_video_top sprite_video_asserts i_video_asserts (
  .clk(clk), .rst(rst), .hpos(hpos), .vpos(vpos), .hsync(hsync), .vsync(vsync), .rgb(rgb)
);

`default_nettype wire

// File: sprite_video_top.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_video_top
  import sprite_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  // host side of the sprite table
  input  logic                       wr_en,
  input  logic [table_addr_bits-1:0] wr_addr,
  input  logic [table_data_bits-1:0] wr_data,
  // video out
  output logic                       hsync,
  output logic                       vsync,
  output logic [pos_bits-1:0]        hpos,
  output logic [pos_bits-1:0]        vpos,
  output logic [color_bits-1:0]      rgb
);

  logic [table_addr_bits-1:0] table_addr;
  logic [table_data_bits-1:0] table_data;
  logic [rom_addr_bits-1:0]   rom_addr;
  logic [rom_data_bits-1:0]   rom_data;

  video_timing i_timing (
    .clk   (clk),
    .rst   (rst),
    .hsync (hsync),
    .vsync (vsync),
    .hpos  (hpos),
    .vpos  (vpos)
  );

  sprite_table i_table (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (table_addr),
    .rd_data (table_data)
  );

  sprite_bitmap_rom i_rom (
    .addr (rom_addr),
    .data (rom_data)
  );

  sprite_scanline_renderer i_renderer (
    .clk        (clk),
    .rst        (rst),
    .hpos       (hpos),
    .vpos       (vpos),
    .table_addr (table_addr),
    .table_data (table_data),
    .rom_addr   (rom_addr),
    .rom_data   (rom_data),
    .rgb        (rgb)
  );

endmodule

`default_nettype wire

// File: src.f
sprite_pkg.sv
video_timing.sv
sprite_table.sv
sprite_bitmap_rom.sv
sprite_scanline_renderer.sv
sprite_video_top.sv
sprite_video_asserts.sv
tb_sprite_video.sv

// File: tb_sprite_video.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sprite_video
  import sprite_pkg::*;
();

  logic                       clk;
  logic                       rst;
  logic                       wr_en;
  logic [table_addr_bits-1:0] wr_addr;
  logic [table_data_bits-1:0] wr_data;
  logic                       hsync;
  logic                       vsync;
  logic [pos_bits-1:0]        hpos;
  logic [pos_bits-1:0]        vpos;
  logic [color_bits-1:0]      rgb;

  logic [table_data_bits-1:0] shadow [table_words]; // what the host has written
  logic [table_data_bits-1:0] snap   [table_words]; // copy taken on the load line
  logic [rom_data_bits-1:0]   bitmap [1 << rom_addr_bits];
  logic                       snap_valid;
  logic                       have_prev;
  int                         ras_h;  // expected raster position
  int                         ras_v;
  int                         prev_h; // raster position rgb belongs to
  int                         prev_v;
  int                         pixel_errors;
  int                         value_errors;
  int                         timeouts;

  sprite_video_top i_dut (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .hsync   (hsync),
    .vsync   (vsync),
    .hpos    (hpos),
    .vpos    (vpos),
    .rgb     (rgb)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period
  end

  // line v shows what was selected on line v-1
  function automatic logic [color_bits-1:0] expected_pixel(input int h, input int v);
    logic [color_bits-1:0] color;
    logic [7:0]            x;
    logic [7:0]            y;
    logic [5:0]            attr;
    int                    row;
    int                    col;
    int                    taken;
    color = '0;
    taken = 0;
    if (!snap_valid || h >= h_visible || v >= v_visible || v == 0) begin
      return '0; // blanking, nothing loaded yet, or line 0
    end
    for (int n = 0; n < sprite_count; n++) begin
      y    = snap[2 * n][15:8];
      x    = snap[2 * n][7:0];
      attr = snap[2 * n + 1][5:0];
      row  = (v - 1 - y) & 255; // band test mod 256
      if (row < sprite_size && taken < slots_per_line) begin
        taken++;
        col = (h - x) & 255;     // x wraps at 256
        if (col < sprite_size && bitmap[{attr[5:4], row[3:0]}][col]) begin
          color = attr[3:0];     // later index overwrites
        end
      end
    end
    return color;
  endfunction

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    assert (actual === expected) else begin
      value_errors++;
      $display("error at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  // one clock of the raster, 320 per line and 262 lines per frame
  task automatic advance_raster();
    if (ras_h == h_total - 1) begin
      ras_h = 0;
      ras_v = (ras_v == v_total - 1) ? 0 : ras_v + 1;
    end else begin
      ras_h = ras_h + 1;
    end
  endtask

  // raster and syncs against the expected position, rgb against the previous one
  task automatic check_cycle();
    logic [color_bits-1:0] exp_rgb;
    check_value("hpos", hpos, 16'(ras_h));
    check_value("vpos", vpos, 16'(ras_v));
    check_value("hsync", hsync, (ras_h >= h_sync_start) && (ras_h < h_sync_end));
    check_value("vsync", vsync, (ras_v >= v_sync_start) && (ras_v < v_sync_end));
    if (have_prev) begin
      exp_rgb = expected_pixel(prev_h, prev_v);
      assert (rgb === exp_rgb) else begin
        pixel_errors++;
        $display("error at %0t: rgb = %0h, expected %0h (hpos %0d, vpos %0d)",
                 $time, rgb, exp_rgb, prev_h, prev_v);
      end
    end
    if (ras_v == v_load_line && ras_h == 0) begin
      for (int i = 0; i < table_words; i++) begin
        snap[i] = shadow[i]; // next frame uses this copy
      end
      snap_valid = 1'b1;
    end
    prev_h    = ras_h;
    prev_v    = ras_v;
    have_prev = 1'b1;
  endtask

  task automatic step();
    @(negedge clk);
    advance_raster();
    check_cycle();
  endtask

  task automatic wait_line(input int target);
    int n;
    n = 0;
    while (timeouts == 0 && vpos != target) begin
      if (n == h_total * v_total + h_total) begin
        timeouts++;
        $display("timeout: vpos never reached line %0d", target);
      end else begin
        step();
        n++;
      end
    end
  endtask

  // load line, then one more so the host may write again
  task automatic next_frame();
    wait_line(v_load_line);
    wait_line(v_load_line + 1);
  endtask

  task automatic write_word(input int addr, input logic [15:0] data);
    int n;
    n = 0;
    while (vpos == v_load_line && n <= h_total) begin // stay off the copy line
      step();
      n++;
    end
    if (vpos == v_load_line) begin
      timeouts++;
      $display("timeout: raster stayed on the copy line for %0d clocks", n);
    end
    wr_en        = 1'b1;
    wr_addr      = addr[table_addr_bits-1:0];
    wr_data      = data;
    shadow[addr] = data;
    step();
    wr_en        = 1'b0;
  endtask

  task automatic write_sprite(input int n, input logic [7:0] x, input logic [7:0] y,
                              input logic [1:0] shape, input logic [3:0] color);
    write_word(2 * n, {y, x});
    write_word(2 * n + 1, {10'b0, shape, color});
  endtask

  task automatic write_random_sprites();
    for (int n = 0; n < sprite_count; n++) begin
      write_word(2 * n, 16'($urandom));     // y and x
      write_word(2 * n + 1, 16'($urandom)); // attribute, unused bits too
    end
  endtask

  // band 240..255 never reaches a visible line
  task automatic park_sprites();
    for (int n = 0; n < sprite_count; n++) begin
      write_sprite(n, 8'd0, 8'd240, 2'd0, 4'd0);
    end
  endtask

  initial begin
    void'($urandom(97872)); // one seed for the whole run
    rst          = 1'b1;
    wr_en        = 1'b0;
    wr_addr      = '0;
    wr_data      = '0;
    snap_valid   = 1'b0;
    have_prev    = 1'b0;
    ras_h        = 0;
    ras_v        = 0;
    prev_h       = 0;
    prev_v       = 0;
    pixel_errors = 0;
    value_errors = 0;
    timeouts     = 0;
    for (int i = 0; i < table_words; i++) begin
      shadow[i] = '0;
    end
    $readmemh("sprite_bitmaps.hex", bitmap);
    repeat (8) @(negedge clk);
    check_value("hpos", hpos, 0);
    check_value("vpos", vpos, 0);
    check_value("hsync", hsync, 0);
    check_value("vsync", vsync, 0);
    check_value("rgb", rgb, 0);
    rst       = 1'b0;
    have_prev = 1'b1; // first rgb after reset is for (0, 0)

    // frame 0 stays black, the table is copied on its line 260
    write_random_sprites();
    next_frame();
    repeat (3) begin
      write_random_sprites(); // lands after the copy, shows a frame later
      next_frame();
    end

    // same spot, two colors; second pair across the right edge
    park_sprites();
    write_sprite(3, 8'd120, 8'd60, 2'd2, 4'h5);
    write_sprite(9, 8'd120, 8'd60, 2'd2, 4'hc);
    write_sprite(1, 8'd248, 8'd150, 2'd3, 4'h2);
    write_sprite(14, 8'd248, 8'd150, 2'd3, 4'h7);
    next_frame();

    // six on one band, four slots
    park_sprites();
    for (int n = 0; n < 6; n++) begin
      write_sprite(n, 8'(10 + 40 * n), 8'd100, 2'd0, 4'(n + 1));
    end
    next_frame();
    wait_line(20);                                  // six-sprite frame on screen
    write_sprite(0, 8'd250, 8'd30, 2'd1, 4'hf);     // late write, next frame unchanged
    next_frame();
    wait_line(v_visible);                           // moved sprite shown here

    $display("summary: %0d pixel errors, %0d value errors, %0d timeouts",
             pixel_errors, value_errors, timeouts);
    if (pixel_errors == 0 && value_errors == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing
  import sprite_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  output logic                hsync,
  output logic                vsync,
  output logic [pos_bits-1:0] hpos,
  output logic [pos_bits-1:0] vpos
);

  logic [pos_bits-1:0] hpos_next;
  logic [pos_bits-1:0] vpos_next;
  logic                line_end;
  logic                frame_end;

  assign line_end  = (hpos == h_total - 1);
  assign frame_end = (vpos == v_total - 1);

  // next raster position, vpos steps when hpos wraps
  always_comb begin
    hpos_next = hpos + 1'b1;
    vpos_next = vpos;
    if (line_end) begin
      hpos_next = '0;
      vpos_next = frame_end ? '0 : vpos + 1'b1;
    end
  end

  // syncs decoded from the next position so they line up with hpos/vpos
  always_ff @(posedge clk) begin
    if (rst) begin
      hpos  <= '0;
      vpos  <= '0;
      hsync <= 1'b0;
      vsync <= 1'b0;
    end else begin
      hpos  <= hpos_next;
      vpos  <= vpos_next;
      hsync <= (hpos_next >= h_sync_start) && (hpos_next < h_sync_end); // 24 clocks
      vsync <= (vpos_next >= v_sync_start) && (vpos_next < v_sync_end); // 3 lines
    end
  end

endmodule

`default_nettype wire
